//--- verilog/heater_pkg.sv
`default_nettype none

package heater_pkg;

	// heater channels driven by the block
	localparam int NUM_HEATERS = 4;

	// 0 is off, 63 is on for the whole PWM period
	typedef logic [5:0] duty_t;

	localparam duty_t DUTY_MAX = 6'd63;

	// one bit per channel
	typedef logic [NUM_HEATERS-1:0] heater_mask_t;

	// amount added or removed per override step
	localparam int DEFAULT_STEP = 6;

endpackage : heater_pkg

`default_nettype wire

//--- verilog/heater_apb_pkg.sv
`default_nettype none

package heater_apb_pkg;

	localparam int APB_ADDR_W = 4;
	localparam int APB_DATA_W = 8;

	// bits 3..0 override enable per channel
	localparam logic [APB_ADDR_W-1:0] REG_OVERRIDE = 4'h0;

	// write only, bits 3..0 increment, bits 7..4 decrement
	localparam logic [APB_ADDR_W-1:0] REG_STEP = 4'h1;

	// first of four read-only effective duties
	localparam logic [APB_ADDR_W-1:0] REG_DUTY0 = 4'h4;

endpackage : heater_apb_pkg

`default_nettype wire

//--- verilog/heater_cmd_if.sv
`timescale 1ns/100ps
`default_nettype none

interface heater_cmd_if;

	import heater_pkg::*;

	heater_mask_t override_en;	// level
	heater_mask_t step_up;		// one-cycle strobe
	heater_mask_t step_down;	// one-cycle strobe

	modport decode_mp (
		output override_en,
		output step_up,
		output step_down
	);

	modport execute_mp (
		input override_en,
		input step_up,
		input step_down
	);

endinterface : heater_cmd_if

`default_nettype wire

//--- verilog/heater_reg_decode.sv
`timescale 1ns/100ps
`default_nettype none

module heater_reg_decode (
	input logic clock_00_0048,
	input logic reset_c,
	input logic [heater_apb_pkg::APB_ADDR_W-1:0] paddr_i,
	input logic psel_i,
	input logic penable_i,
	input logic pwrite_i,
	input logic [heater_apb_pkg::APB_DATA_W-1:0] pwdata_i,
	output logic [heater_apb_pkg::APB_DATA_W-1:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,
	input heater_pkg::duty_t eff_duty_i [heater_pkg::NUM_HEATERS],
	heater_cmd_if.decode_mp cmd
);

	import heater_pkg::*;
	import heater_apb_pkg::*;

	localparam int IDX_W = $clog2(NUM_HEATERS);

	logic access;
	logic is_override;
	logic is_step;
	logic is_duty;
	logic bad_access;
	logic wr_en;
	logic [IDX_W-1:0] duty_idx;

	assign access = psel_i & penable_i;	// completing cycle

	assign is_override = (paddr_i == REG_OVERRIDE);
	assign is_step = (paddr_i == REG_STEP);
	assign is_duty = (paddr_i >= REG_DUTY0) && (paddr_i < REG_DUTY0 + NUM_HEATERS);
	assign duty_idx = IDX_W'(paddr_i - REG_DUTY0);

	// duty registers are read only
	assign bad_access = ~(is_override | is_step | is_duty) | (pwrite_i & is_duty);

	assign wr_en = access & pwrite_i & ~bad_access;

	assign pready_o = access;	// no wait states
	assign pslverr_o = access & bad_access;

	always_ff @(posedge clock_00_0048 or posedge reset_c)
	begin
		if (reset_c)
		begin
			cmd.override_en <= '0;
			cmd.step_up <= '0;
			cmd.step_down <= '0;
		end
		else
		begin
			if (wr_en && is_override)
				cmd.override_en <= pwdata_i[NUM_HEATERS-1:0];

			// step masks only live for the cycle after the write
			if (wr_en && is_step)
			begin
				cmd.step_up <= pwdata_i[NUM_HEATERS-1:0];
				cmd.step_down <= pwdata_i[2*NUM_HEATERS-1:NUM_HEATERS];
			end
			else
			begin
				cmd.step_up <= '0;
				cmd.step_down <= '0;
			end
		end
	end

	// STEP and unmapped reads return 0
	always_comb
	begin
		prdata_o = '0;
		if (access && !pwrite_i)
		begin
			if (is_override)
				prdata_o[NUM_HEATERS-1:0] = cmd.override_en;
			else if (is_duty)
				prdata_o[$bits(duty_t)-1:0] = eff_duty_i[duty_idx];
		end
	end

	// APB needs a setup cycle between accesses, so strobes never run back to back
	a_step_one_cycle : assert property (
		@(posedge clock_00_0048) disable iff (reset_c)
		((cmd.step_up | cmd.step_down) != '0) |=> ((cmd.step_up | cmd.step_down) == '0)
	);

endmodule : heater_reg_decode

`default_nettype wire

//--- verilog/heater_duty_execute.sv
`timescale 1ns/100ps
`default_nettype none

module heater_duty_execute #(
	parameter int STEP_SIZE = heater_pkg::DEFAULT_STEP
) (
	input logic clock_00_0048,
	input logic reset_c,
	heater_cmd_if.execute_mp cmd,
	input heater_pkg::duty_t ctrl_duty_i [heater_pkg::NUM_HEATERS],
	output heater_pkg::duty_t eff_duty_o [heater_pkg::NUM_HEATERS]
);

	import heater_pkg::*;

	duty_t ovr_duty [NUM_HEATERS];

	for (genvar i = 0; i < NUM_HEATERS; i++)
	begin : g_chan
		logic at_top;
		logic at_bottom;

		// would the next step leave the 0..63 range
		assign at_top = (int'(ovr_duty[i]) + STEP_SIZE) >= int'(DUTY_MAX);
		assign at_bottom = int'(ovr_duty[i]) <= STEP_SIZE;

		always_ff @(posedge clock_00_0048 or posedge reset_c)
		begin
			if (reset_c)
				ovr_duty[i] <= '0;
			else if (cmd.step_up[i])	// increment wins over decrement
			begin
				if (at_top)
					ovr_duty[i] <= DUTY_MAX;
				else
					ovr_duty[i] <= ovr_duty[i] + duty_t'(STEP_SIZE);
			end
			else if (cmd.step_down[i])
			begin
				if (at_bottom)
					ovr_duty[i] <= '0;
				else
					ovr_duty[i] <= ovr_duty[i] - duty_t'(STEP_SIZE);
			end
		end

		assign eff_duty_o[i] = cmd.override_en[i] ? ovr_duty[i] : ctrl_duty_i[i];

		// only a strobe from the register decode may move the override duty
		a_duty_needs_strobe : assert property (
			@(posedge clock_00_0048) disable iff (reset_c)
			!(cmd.step_up[i] || cmd.step_down[i]) |=> $stable(ovr_duty[i])
		);
	end

endmodule : heater_duty_execute

`default_nettype wire

//--- verilog/heater_pwm_result.sv
`timescale 1ns/100ps
`default_nettype none

module heater_pwm_result (
	input logic clock_00_0048,
	input logic reset_c,
	input heater_pkg::duty_t eff_duty_i [heater_pkg::NUM_HEATERS],
	output heater_pkg::heater_mask_t heater_en_o
);

	import heater_pkg::*;

	duty_t pwm_cnt;	// wraps every 64 cycles

	always_ff @(posedge clock_00_0048 or posedge reset_c)
	begin
		if (reset_c)
		begin
			pwm_cnt <= '0;
			heater_en_o <= '0;
		end
		else
		begin
			pwm_cnt <= pwm_cnt + 1'b1;
			for (int i = 0; i < NUM_HEATERS; i++)
			begin
				// duty d gives d+1 on cycles per period
				heater_en_o[i] <= (eff_duty_i[i] != '0) && (pwm_cnt <= eff_duty_i[i]);
			end
		end
	end

	for (genvar i = 0; i < NUM_HEATERS; i++)
	begin : g_chk
		a_zero_duty_off : assert property (
			@(posedge clock_00_0048) disable iff (reset_c)
			(eff_duty_i[i] == '0) |=> !heater_en_o[i]
		);
	end

endmodule : heater_pwm_result

`default_nettype wire

//--- verilog/heater_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

module heater_ctrl_top (
	input logic clock_00_0048,
	input logic reset_c,
	input logic [heater_apb_pkg::APB_ADDR_W-1:0] paddr_i,
	input logic psel_i,
	input logic penable_i,
	input logic pwrite_i,
	input logic [heater_apb_pkg::APB_DATA_W-1:0] pwdata_i,
	output logic [heater_apb_pkg::APB_DATA_W-1:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,
	input heater_pkg::duty_t ctrl_duty_i [heater_pkg::NUM_HEATERS],
	output heater_pkg::heater_mask_t heater_en_o
);

	import heater_pkg::*;

	duty_t eff_duty [NUM_HEATERS];	// duty each channel actually runs at

	heater_cmd_if cmd_if ();

	heater_reg_decode i_decode (
		.clock_00_0048 (clock_00_0048),
		.reset_c       (reset_c),
		.paddr_i       (paddr_i),
		.psel_i        (psel_i),
		.penable_i     (penable_i),
		.pwrite_i      (pwrite_i),
		.pwdata_i      (pwdata_i),
		.prdata_o      (prdata_o),
		.pready_o      (pready_o),
		.pslverr_o     (pslverr_o),
		.eff_duty_i    (eff_duty),
		.cmd           (cmd_if.decode_mp)
	);

	heater_duty_execute #(
		.STEP_SIZE (DEFAULT_STEP)
	) i_execute (
		.clock_00_0048 (clock_00_0048),
		.reset_c       (reset_c),
		.cmd           (cmd_if.execute_mp),
		.ctrl_duty_i   (ctrl_duty_i),
		.eff_duty_o    (eff_duty)
	);

	heater_pwm_result i_pwm (
		.clock_00_0048 (clock_00_0048),
		.reset_c       (reset_c),
		.eff_duty_i    (eff_duty),
		.heater_en_o   (heater_en_o)
	);

endmodule : heater_ctrl_top

`default_nettype wire

//--- tests/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
	parameter int HALF_PERIOD = 10,
	parameter int RESET_CYCLES = 10
) (
	output logic clock_o,
	output logic reset_o
);

	initial
	begin
		clock_o = 1'b0;
		forever
			#(HALF_PERIOD) clock_o = ~clock_o;
	end

	initial
	begin
		reset_o = 1'b0;
		#1;
		reset_o = 1'b1;
		repeat (RESET_CYCLES)
			@(posedge clock_o);
		#1;
		reset_o = 1'b0;	// released just after an edge
	end

endmodule : tb_clock_gen

`default_nettype wire

//--- tests/heater_ctrl_tb.sv
`timescale 1ns/100ps
`default_nettype none

module heater_ctrl_tb;

	import heater_pkg::*;
	import heater_apb_pkg::*;

	localparam int SEED_INIT = 32'h58ba519f;
	localparam int RESET_TIMEOUT = 50;
	localparam int READY_TIMEOUT = 8;
	localparam int PWM_PERIOD = 64;

	logic clock_00_0048;
	logic reset_c;
	logic [APB_ADDR_W-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [APB_DATA_W-1:0] pwdata;
	logic [APB_DATA_W-1:0] prdata;
	logic pready;
	logic pslverr;
	duty_t ctrl_duty [NUM_HEATERS];
	heater_mask_t heater_en;

	// reference model state
	heater_mask_t model_ovr_en;
	duty_t model_ovr_duty [NUM_HEATERS];

	integer seed;

	tb_clock_gen i_clk_gen (
		.clock_o (clock_00_0048),
		.reset_o (reset_c)
	);

	heater_ctrl_top i_dut (
		.clock_00_0048 (clock_00_0048),
		.reset_c       (reset_c),
		.paddr_i       (paddr),
		.psel_i        (psel),
		.penable_i     (penable),
		.pwrite_i      (pwrite),
		.pwdata_i      (pwdata),
		.prdata_o      (prdata),
		.pready_o      (pready),
		.pslverr_o     (pslverr),
		.ctrl_duty_i   (ctrl_duty),
		.heater_en_o   (heater_en)
	);

	task automatic report_failure(input string what);
		$display("ERROR: %s", what);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string test, input int expected, input int actual);
		$display("MISMATCH %s: expected %0d, actual %0d", test, expected, actual);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_equal(input string test, input int expected, input int actual);
		assert (expected == actual)
		else
			report_mismatch(test, expected, actual);
	endtask

	// slave never inserts wait states
	a_ready_in_access : assert property (
		@(posedge clock_00_0048) disable iff (reset_c)
		(psel && penable) |-> pready
	) else report_failure("pready_o low in an APB access phase");

	a_no_err_outside_access : assert property (
		@(posedge clock_00_0048)
		!(psel && penable) |-> !pslverr
	) else report_failure("pslverr_o high outside an APB access phase");

	a_heaters_off_in_reset : assert property (
		@(posedge clock_00_0048)
		reset_c |-> (heater_en == '0) ##1 (heater_en == '0)
	) else report_failure("heater_en_o not zero during or right after reset");

	function automatic duty_t expected_duty(input int ch);
		return model_ovr_en[ch] ? model_ovr_duty[ch] : ctrl_duty[ch];
	endfunction

	task automatic apb_access(input logic write, input logic [APB_ADDR_W-1:0] addr,
			input logic [APB_DATA_W-1:0] wdata, output logic [APB_DATA_W-1:0] rdata,
			output logic err);
		int waited;
		waited = 0;
		@(posedge clock_00_0048);
		#1;
		psel = 1'b1;	// setup phase
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = write ? wdata : '0;
		@(posedge clock_00_0048);
		#1;
		penable = 1'b1;
		@(negedge clock_00_0048);
		while (!pready)
		begin
			waited++;
			if (waited >= READY_TIMEOUT)
				report_failure("pready_o never rose during an APB access");
			else
				@(negedge clock_00_0048);
		end
		rdata = prdata;
		err = pslverr;
		@(posedge clock_00_0048);	// access completes here
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [APB_DATA_W-1:0] data,
			input logic exp_err, input string name);
		logic [APB_DATA_W-1:0] rdata;
		logic err;
		apb_access(1'b1, addr, data, rdata, err);
		check_equal({name, "_pslverr"}, exp_err, err);
	endtask

	task automatic apb_read_check(input logic [APB_ADDR_W-1:0] addr, input int expected,
			input string name);
		logic [APB_DATA_W-1:0] rdata;
		logic err;
		apb_access(1'b0, addr, '0, rdata, err);
		check_equal({name, "_pslverr"}, 0, err);
		check_equal(name, expected, rdata);
	endtask

	task automatic apb_read_error(input logic [APB_ADDR_W-1:0] addr, input string name);
		logic [APB_DATA_W-1:0] rdata;
		logic err;
		apb_access(1'b0, addr, '0, rdata, err);
		check_equal({name, "_pslverr"}, 1, err);
	endtask

	task automatic write_override(input heater_mask_t mask, input string name);
		apb_write(REG_OVERRIDE, APB_DATA_W'(mask), 1'b0, name);
		model_ovr_en = mask;
	endtask

	task automatic step_write(input heater_mask_t up, input heater_mask_t down, input string name);
		int nxt;
		apb_write(REG_STEP, {down, up}, 1'b0, name);
		for (int i = 0; i < NUM_HEATERS; i++)
		begin
			nxt = model_ovr_duty[i];
			if (up[i])	// increment wins
				nxt = (nxt + DEFAULT_STEP > DUTY_MAX) ? DUTY_MAX : nxt + DEFAULT_STEP;
			else if (down[i])
				nxt = (nxt < DEFAULT_STEP) ? 0 : nxt - DEFAULT_STEP;
			model_ovr_duty[i] = duty_t'(nxt);
		end
	endtask

	task automatic randomize_ctrl();
		@(posedge clock_00_0048);
		#1;
		for (int i = 0; i < NUM_HEATERS; i++)
			ctrl_duty[i] = duty_t'($random(seed));
	endtask

	task automatic set_ctrl(input int d0, input int d1, input int d2, input int d3);
		@(posedge clock_00_0048);
		#1;
		ctrl_duty[0] = duty_t'(d0);
		ctrl_duty[1] = duty_t'(d1);
		ctrl_duty[2] = duty_t'(d2);
		ctrl_duty[3] = duty_t'(d3);
	endtask

	task automatic check_readback(input string name);
		apb_read_check(REG_OVERRIDE, model_ovr_en, {name, "_override"});
		for (int i = 0; i < NUM_HEATERS; i++)
			apb_read_check(REG_DUTY0 + APB_ADDR_W'(i), expected_duty(i),
				$sformatf("%s_duty%0d", name, i));
	endtask

	// count enable cycles over one full PWM period
	task automatic pwm_count_check(input string name);
		int on_cnt [NUM_HEATERS];
		int d;
		for (int i = 0; i < NUM_HEATERS; i++)
			on_cnt[i] = 0;
		repeat (2)
			@(posedge clock_00_0048);
		repeat (PWM_PERIOD)
		begin
			@(negedge clock_00_0048);
			for (int i = 0; i < NUM_HEATERS; i++)
				on_cnt[i] += heater_en[i];
		end
		for (int i = 0; i < NUM_HEATERS; i++)
		begin
			d = expected_duty(i);
			check_equal($sformatf("%s_ch%0d", name, i), (d == 0) ? 0 : d + 1, on_cnt[i]);
		end
	endtask

	initial
	begin
		int waited;
		int rnd;
		seed = SEED_INIT;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		model_ovr_en = '0;
		for (int i = 0; i < NUM_HEATERS; i++)
		begin
			ctrl_duty[i] = '0;
			model_ovr_duty[i] = '0;
		end

		@(posedge clock_00_0048);
		apb_read_check(REG_OVERRIDE, 0, "override_in_reset");

		waited = 0;
		while (reset_c)
		begin
			waited++;
			if (waited >= RESET_TIMEOUT)
				report_failure("reset_c never released");
			else
				@(posedge clock_00_0048);
		end
		check_readback("after_reset");

		// controller duties pass through with override off
		repeat (6)
		begin
			randomize_ctrl();
			check_readback("ctrl_passthrough");
		end

		set_ctrl(0, 1, 32, 63);
		pwm_count_check("pwm_fixed");
		repeat (3)
		begin
			randomize_ctrl();
			pwm_count_check("pwm_random");
		end

		write_override(4'hf, "override_all");
		check_readback("override_on");
		repeat (12)
		begin
			step_write(4'hf, 4'h0, "step_up");
			check_readback("step_up_sat");
		end
		repeat (12)
		begin
			step_write(4'h0, 4'hf, "step_down");
			check_readback("step_down_sat");
		end
		repeat (20)
		begin
			rnd = $random(seed);
			step_write(rnd[3:0], rnd[7:4], "step_random");
			check_readback("step_random");
		end
		pwm_count_check("pwm_override");

		// steps still land on the stored duty while override is off
		write_override(4'h0, "override_off");
		randomize_ctrl();
		step_write(4'b0101, 4'b0010, "hidden_step_a");
		step_write(4'b1101, 4'b0000, "hidden_step_b");
		check_readback("hidden_steps");
		write_override(4'hf, "override_back_on");
		check_readback("hidden_steps_visible");

		step_write(4'hf, 4'hf, "both_bits");
		check_readback("both_bits");
		step_write(4'h0, 4'h0, "zero_step");
		check_readback("zero_step");
		apb_read_check(REG_STEP, 0, "step_reads_zero");

		write_override(4'b1010, "override_mixed");
		check_readback("override_mixed");

		// error responses leave everything as it was
		apb_write(REG_DUTY0 + 4'd1, 8'hff, 1'b1, "duty_write");
		check_readback("after_duty_write");
		for (int a = 2; a < 16; a++)
		begin
			if (a == 2 || a == 3 || a >= 8)
			begin
				apb_write(APB_ADDR_W'(a), 8'hff, 1'b1, $sformatf("unmapped_wr%0d", a));
				apb_read_error(APB_ADDR_W'(a), $sformatf("unmapped_rd%0d", a));
			end
		end
		check_readback("after_unmapped");

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule : heater_ctrl_tb

`default_nettype wire

//--- heater_ctrl.f
verilog/heater_pkg.sv
verilog/heater_apb_pkg.sv
verilog/heater_cmd_if.sv
verilog/heater_reg_decode.sv
verilog/heater_duty_execute.sv
verilog/heater_pwm_result.sv
verilog/heater_ctrl_top.sv
tests/tb_clock_gen.sv
tests/heater_ctrl_tb.sv
